//--- hdl/pck_mem_bus.sv
// data bus package holding the bus widths and the request and response structs
package pck_mem_bus;

  localparam int BUS_ADDR_W = 32;  // byte address
  localparam int BUS_DATA_W = 32;
  localparam int BUS_BE_W   = BUS_DATA_W / 8;

  // one access from the bus master, 70 bits
  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_BE_W-1:0]   be;       // write byte enables
    logic                  wr_en;
    logic [BUS_DATA_W-1:0] wr_data;
    logic                  rd_en;
  } mem_req_t;

  // one response, ack is a single cycle pulse
  typedef struct packed {
    logic [BUS_DATA_W-1:0] rd_data;
    logic                  ack;
  } mem_rsp_t;

  // byte-wise merge of a bus write into an existing word
  function automatic logic [BUS_DATA_W-1:0] be_merge(
    input logic [BUS_DATA_W-1:0] old_data,
    input logic [BUS_DATA_W-1:0] new_data,
    input logic [BUS_BE_W-1:0]   be
  );
    logic [BUS_DATA_W-1:0] merged;
    merged = old_data;
    for (int i = 0; i < BUS_BE_W; i++) begin
      if (be[i]) merged[8*i +: 8] = new_data[8*i +: 8];
    end
    return merged;
  endfunction

endpackage

//--- hdl/pck_memory_map.sv
// memory map package with peripheral windows, bridge targets and register offsets
package pck_memory_map;

  // peripheral windows, matched as (addr & mask) == base
  localparam logic [31:0] GPIO_ADDR      = 32'h4000_0000;
  localparam logic [31:0] GPIO_ADDR_MASK = 32'hffff_ff00;

  localparam logic [31:0] PWM0_ADDR      = 32'h4000_0100;
  localparam logic [31:0] PWM0_ADDR_MASK = 32'hffff_ff00;

  // bridge targets
  typedef enum logic [1:0] {
    GPIO_ID,
    PWM0_ID,
    NO_PERIPH  // no window hit
  } bridge_id_e;

  // gpio word offsets
  typedef enum logic [1:0] {
    GPIO_OUT    = 2'd0,
    GPIO_OUT_EN = 2'd1,
    GPIO_IN     = 2'd2   // read only
  } gpio_reg_e;

  // pwm word offsets
  typedef enum logic [2:0] {
    PWM_CTRL   = 3'd0,   // bit 0 is enable
    PWM_PERIOD = 3'd1,
    PWM_CMP0   = 3'd2,
    PWM_CMP1   = 3'd3
  } pwm_reg_e;

endpackage

//--- hdl/soc_bridge.sv
// data bus bridge decoding each access to gpio, pwm or the unmapped responder
module soc_bridge (
  input  wire                   i_clk,
  input  wire                   i_rst,

  input  pck_mem_bus::mem_req_t i_req,       // from bus master
  output pck_mem_bus::mem_rsp_t o_rsp,       // merged response

  output pck_mem_bus::mem_req_t o_gpio_req,
  input  pck_mem_bus::mem_rsp_t i_gpio_rsp,

  output pck_mem_bus::mem_req_t o_pwm_req,
  input  pck_mem_bus::mem_rsp_t i_pwm_rsp
);

  import pck_mem_bus::*;
  import pck_memory_map::*;

  bridge_id_e target;
  logic       strobe;
  logic       unmapped_ack;
  mem_rsp_t   unmapped_rsp;

  assign strobe = i_req.wr_en | i_req.rd_en;

  // window decode, gpio has priority on overlap
  always_comb begin
    if ((i_req.addr & GPIO_ADDR_MASK) == GPIO_ADDR) begin
      target = GPIO_ID;
    end else if ((i_req.addr & PWM0_ADDR_MASK) == PWM0_ADDR) begin
      target = PWM0_ID;
    end else begin
      target = NO_PERIPH;
    end
  end

  // payload goes to both, strobes only to the selected target
  always_comb begin
    o_gpio_req       = i_req;
    o_gpio_req.wr_en = i_req.wr_en && (target == GPIO_ID);
    o_gpio_req.rd_en = i_req.rd_en && (target == GPIO_ID);

    o_pwm_req        = i_req;
    o_pwm_req.wr_en  = i_req.wr_en && (target == PWM0_ID);
    o_pwm_req.rd_en  = i_req.rd_en && (target == PWM0_ID);
  end

  // answer accesses that hit no window so the master never hangs
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      unmapped_ack <= 1'b0;
    end else begin
      unmapped_ack <= strobe && (target == NO_PERIPH);
    end
  end

  assign unmapped_rsp.rd_data = '0;
  assign unmapped_rsp.ack     = unmapped_ack;

  // idle targets drive zero, so a plain OR merges them
  assign o_rsp = mem_rsp_t'(i_gpio_rsp | i_pwm_rsp | unmapped_rsp);

  // one target per access
  a_single_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_gpio_rsp.ack && i_pwm_rsp.ack));

  // no access is dropped whatever the address
  a_strobe_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    strobe |=> o_rsp.ack);

endmodule

//--- hdl/perif_gpio.sv
// gpio block with output and output enable registers and a synchronized input port
module perif_gpio #(
  parameter int p_num_gpios = 16
)(
  input  wire                    i_clk,
  input  wire                    i_rst,

  input  pck_mem_bus::mem_req_t  i_req,
  output pck_mem_bus::mem_rsp_t  o_rsp,

  input  wire  [p_num_gpios-1:0] i_gpio_in,      // asynchronous pins
  output logic [p_num_gpios-1:0] o_gpio_out,
  output logic [p_num_gpios-1:0] o_gpio_out_en
);

  import pck_mem_bus::*;
  import pck_memory_map::*;

  logic [7:0]             word;        // word offset inside the window
  logic [p_num_gpios-1:0] gpio_meta;   // first sync stage
  logic [p_num_gpios-1:0] gpio_sync;
  logic [BUS_DATA_W-1:0]  rd_word;

  assign word = i_req.addr[9:2];

  // GPIO_IN and unused offsets ignore writes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_gpio_out    <= '0;
      o_gpio_out_en <= '0;
    end else if (i_req.wr_en) begin
      case (word)
        8'(GPIO_OUT): begin
          o_gpio_out <= p_num_gpios'(be_merge(BUS_DATA_W'(o_gpio_out),
                                              i_req.wr_data, i_req.be));
        end
        8'(GPIO_OUT_EN): begin
          o_gpio_out_en <= p_num_gpios'(be_merge(BUS_DATA_W'(o_gpio_out_en),
                                                 i_req.wr_data, i_req.be));
        end
        default: ;
      endcase
    end
  end

  // two flop synchronizer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= i_gpio_in;
      gpio_sync <= gpio_meta;
    end
  end

  // read mux
  always_comb begin
    case (word)
      8'(GPIO_OUT):    rd_word = BUS_DATA_W'(o_gpio_out);
      8'(GPIO_OUT_EN): rd_word = BUS_DATA_W'(o_gpio_out_en);
      8'(GPIO_IN):     rd_word = BUS_DATA_W'(gpio_sync);
      default:         rd_word = '0;
    endcase
  end

  // single cycle response with data only on reads
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp <= '0;
    end else begin
      o_rsp.ack     <= i_req.wr_en | i_req.rd_en;
      o_rsp.rd_data <= i_req.rd_en ? rd_word : '0;
    end
  end

  // a full word write to OUT is acked and on the pins one cycle later
  a_out_write: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req.wr_en && (word == 8'(GPIO_OUT)) && (i_req.be == '1))
    |=> (o_rsp.ack && (o_gpio_out == p_num_gpios'($past(i_req.wr_data)))));

endmodule

//--- hdl/perif_pwm.sv
// pwm block with a wrapping counter and one registered compare output per channel
module perif_pwm #(
  parameter int p_cmp_width    = 16,
  parameter int p_num_channels = 2    // at most 2 as there are two compare offsets
)(
  input  wire                       i_clk,
  input  wire                       i_rst,

  input  pck_mem_bus::mem_req_t     i_req,
  output pck_mem_bus::mem_rsp_t     o_rsp,

  output logic [p_num_channels-1:0] o_pwm_out
);

  import pck_mem_bus::*;
  import pck_memory_map::*;

  logic [7:0]             word;
  logic [p_cmp_width-1:0] ctrl;
  logic [p_cmp_width-1:0] period;   // last counter value before wrap
  logic [p_cmp_width-1:0] cmp [p_num_channels];
  logic [p_cmp_width-1:0] cnt;
  logic                   enable;
  logic [BUS_DATA_W-1:0]  rd_word;

  assign word   = {2'b00, i_req.addr[7:2]};  // word offset inside the 256 byte window
  assign enable = ctrl[0];

  // register writes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ctrl   <= '0;
      period <= '0;
      for (int n = 0; n < p_num_channels; n++) begin
        cmp[n] <= '0;
      end
    end else if (i_req.wr_en) begin
      case (word)
        8'(PWM_CTRL):   ctrl   <= p_cmp_width'(be_merge(BUS_DATA_W'(ctrl),
                                                        i_req.wr_data, i_req.be));
        8'(PWM_PERIOD): period <= p_cmp_width'(be_merge(BUS_DATA_W'(period),
                                                        i_req.wr_data, i_req.be));
        default: ;
      endcase
      for (int n = 0; n < p_num_channels; n++) begin
        if (word == 8'(PWM_CMP0) + 8'(n)) begin  // compare regs are consecutive
          cmp[n] <= p_cmp_width'(be_merge(BUS_DATA_W'(cmp[n]),
                                          i_req.wr_data, i_req.be));
        end
      end
    end
  end

  // counter runs 0..period and parks at 0 while disabled
  always_ff @(posedge i_clk) begin
    if (i_rst || !enable) begin
      cnt <= '0;
    end else if (cnt >= period) begin
      cnt <= '0;  // also catches a period lowered below cnt
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // compare outputs
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pwm_out <= '0;
    end else begin
      for (int n = 0; n < p_num_channels; n++) begin
        o_pwm_out[n] <= enable && (cnt < cmp[n]);
      end
    end
  end

  // read mux
  always_comb begin
    case (word)
      8'(PWM_CTRL):   rd_word = BUS_DATA_W'(ctrl);
      8'(PWM_PERIOD): rd_word = BUS_DATA_W'(period);
      default:        rd_word = '0;
    endcase
    for (int n = 0; n < p_num_channels; n++) begin
      if (word == 8'(PWM_CMP0) + 8'(n)) rd_word = BUS_DATA_W'(cmp[n]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp <= '0;
    end else begin
      o_rsp.ack     <= i_req.wr_en | i_req.rd_en;
      o_rsp.rd_data <= i_req.rd_en ? rd_word : '0;  // zero on writes
    end
  end

  // a bus write clearing enable silences the channels once it has landed
  a_disabled_low: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req.wr_en && (word == 8'(PWM_CTRL)) && i_req.be[0] && !i_req.wr_data[0])
    |=> ##1 (o_pwm_out == '0));

endmodule

//--- hdl/soc_periph.sv
// peripheral subsystem top joining the data bus bridge with the gpio and pwm blocks
module soc_periph #(
  parameter int p_num_gpios    = 16,
  parameter int p_cmp_width    = 16,
  parameter int p_num_channels = 2
)(
  input  wire                       i_clk,
  input  wire                       i_rst,

  input  pck_mem_bus::mem_req_t     i_req,          // data bus
  output pck_mem_bus::mem_rsp_t     o_rsp,

  input  wire  [p_num_gpios-1:0]    i_gpio_in,
  output logic [p_num_gpios-1:0]    o_gpio_out,
  output logic [p_num_gpios-1:0]    o_gpio_out_en,

  output logic [p_num_channels-1:0] o_pwm_out
);

  import pck_mem_bus::*;

  // routed buses
  mem_req_t gpio_req;
  mem_rsp_t gpio_rsp;
  mem_req_t pwm_req;
  mem_rsp_t pwm_rsp;

  soc_bridge bridge (
    .i_clk          ( i_clk         ),
    .i_rst          ( i_rst         ),
    .i_req          ( i_req         ),
    .o_rsp          ( o_rsp         ),
    .o_gpio_req     ( gpio_req      ),
    .i_gpio_rsp     ( gpio_rsp      ),
    .o_pwm_req      ( pwm_req       ),
    .i_pwm_rsp      ( pwm_rsp       )
  );

  perif_gpio #(
    .p_num_gpios    ( p_num_gpios   )
  ) gpio (
    .i_clk          ( i_clk         ),
    .i_rst          ( i_rst         ),
    .i_req          ( gpio_req      ),
    .o_rsp          ( gpio_rsp      ),
    .i_gpio_in      ( i_gpio_in     ),
    .o_gpio_out     ( o_gpio_out    ),
    .o_gpio_out_en  ( o_gpio_out_en )
  );

  perif_pwm #(
    .p_cmp_width    ( p_cmp_width    ),
    .p_num_channels ( p_num_channels )
  ) pwm0 (
    .i_clk          ( i_clk         ),
    .i_rst          ( i_rst         ),
    .i_req          ( pwm_req       ),
    .o_rsp          ( pwm_rsp       ),
    .o_pwm_out      ( o_pwm_out     )
  );

endmodule

//--- testbench/tb_checks.svh
// testbench helpers with the random source, typed compares and the error counters
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned mismatch_cnt = 0;
int unsigned fail_cnt     = 0;       // timeouts and lost acks
logic [31:0] rng_state    = 32'hffda;

// 32 bit xorshift, 13/17/5 shifts
function automatic logic [31:0] xorshift();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// bus word compare, also used for zero extended pins
task automatic compare_word(input string name, input logic [BUS_DATA_W-1:0] exp,
                            input logic [BUS_DATA_W-1:0] act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("mismatch %s: expected %h, got %h", name, exp, act);
  end
endtask

// high cycle count of one pwm channel
task automatic count_check(input string name, input int exp, input int act);
  if (act != exp) begin
    mismatch_cnt++;
    $display("mismatch %s: expected %h, got %h", name, exp, act);
  end
endtask

`endif

//--- testbench/tb_soc_periph.sv
// testbench for the peripheral subsystem driving the data bus and checking gpio and pwm
module tb_soc_periph;

  import pck_mem_bus::*;
  import pck_memory_map::*;

  localparam int p_num_gpios    = 16;
  localparam int p_cmp_width    = 16;
  localparam int p_num_channels = 2;
  localparam int TIMEOUT        = 20;  // cycles per wait
  localparam logic [31:0] GPIO_MASK = 32'((64'd1 << p_num_gpios) - 1);
  localparam logic [31:0] CMP_MASK  = 32'((64'd1 << p_cmp_width) - 1);
  localparam logic [31:0] NO_ADDR   = 32'h5000_0010;  // outside both windows

  logic                      clk;
  logic                      rst;
  mem_req_t                  req;
  mem_rsp_t                  rsp;
  logic [p_num_gpios-1:0]    gpio_in;
  logic [p_num_gpios-1:0]    gpio_out;
  logic [p_num_gpios-1:0]    gpio_out_en;
  logic [p_num_channels-1:0] pwm_out;

  `include "tb_checks.svh"

  initial clk = 1'b0;
  always #10 clk = ~clk;

  soc_periph #(
    .p_num_gpios    ( p_num_gpios    ),
    .p_cmp_width    ( p_cmp_width    ),
    .p_num_channels ( p_num_channels )
  ) soc_periph_i (
    .i_clk          ( clk            ),
    .i_rst          ( rst            ),
    .i_req          ( req            ),
    .o_rsp          ( rsp            ),
    .i_gpio_in      ( gpio_in        ),
    .o_gpio_out     ( gpio_out       ),
    .o_gpio_out_en  ( gpio_out_en    ),
    .o_pwm_out      ( pwm_out        )
  );

  function automatic logic [31:0] reg_addr(input logic [31:0] base, input int word);
    return base + 32'(word * 4);
  endfunction

  // byte enables to a 32 bit write mask
  function automatic logic [31:0] expand_be(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic logic [31:0] apply_write(input logic [31:0] old_val,
                                              input logic [31:0] data,
                                              input logic [3:0]  be,
                                              input logic [31:0] width_mask);
    return ((old_val & ~expand_be(be)) | (data & expand_be(be))) & width_mask;
  endfunction

  // poll ack at posedge+2 with the request already on the bus
  task automatic wait_ack(input logic [31:0] addr);
    int waited;
    waited = 0;
    if (rsp.ack) begin
      fail_cnt++;
      $display("ack still high when the access to address %h was issued", addr);
    end
    @(posedge clk);
    #2;
    req = '0;
    while (!rsp.ack && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!rsp.ack) begin
      fail_cnt++;
      $display("no ack within %0d cycles for access to address %h", TIMEOUT, addr);
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    @(posedge clk);
    #2;
    req         = '0;
    req.addr    = addr;
    req.be      = be;
    req.wr_data = data;
    req.wr_en   = 1'b1;
    wait_ack(addr);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    req       = '0;
    req.addr  = addr;
    req.rd_en = 1'b1;
    wait_ack(addr);
    data = rsp.rd_data;
  endtask

  task automatic reset_values();
    logic [31:0] addrs [7];
    logic [31:0] rdata;
    addrs[0] = reg_addr(GPIO_ADDR, GPIO_OUT);
    addrs[1] = reg_addr(GPIO_ADDR, GPIO_OUT_EN);
    addrs[2] = reg_addr(GPIO_ADDR, GPIO_IN);
    addrs[3] = reg_addr(PWM0_ADDR, PWM_CTRL);
    addrs[4] = reg_addr(PWM0_ADDR, PWM_PERIOD);
    addrs[5] = reg_addr(PWM0_ADDR, PWM_CMP0);
    addrs[6] = reg_addr(PWM0_ADDR, PWM_CMP1);
    compare_word("o_gpio_out", '0, 32'(gpio_out));
    compare_word("o_gpio_out_en", '0, 32'(gpio_out_en));
    compare_word("o_pwm_out", '0, 32'(pwm_out));
    foreach (addrs[i]) begin
      bus_read(addrs[i], rdata);
      compare_word($sformatf("rd_data @%h", addrs[i]), '0, rdata);
    end
  endtask

  task automatic gpio_write_readback();
    logic [31:0] exp_out;
    logic [31:0] exp_en;
    logic [31:0] data;
    logic [3:0]  be;
    logic [31:0] rdata;
    exp_out = '0;  // from reset
    exp_en  = '0;
    for (int i = 0; i < 4; i++) begin
      data = xorshift();
      be   = 4'(xorshift());
      bus_write(reg_addr(GPIO_ADDR, GPIO_OUT), data, be);
      exp_out = apply_write(exp_out, data, be, GPIO_MASK);
      compare_word("o_gpio_out", exp_out, 32'(gpio_out));
      data = xorshift();
      be   = 4'(xorshift());
      bus_write(reg_addr(GPIO_ADDR, GPIO_OUT_EN), data, be);
      exp_en = apply_write(exp_en, data, be, GPIO_MASK);
      compare_word("o_gpio_out_en", exp_en, 32'(gpio_out_en));
      bus_read(reg_addr(GPIO_ADDR, GPIO_OUT), rdata);
      compare_word("GPIO_OUT rd_data", exp_out, rdata);
      bus_read(reg_addr(GPIO_ADDR, GPIO_OUT_EN), rdata);
      compare_word("GPIO_OUT_EN rd_data", exp_en, rdata);
    end
    // input register is read only
    bus_write(reg_addr(GPIO_ADDR, GPIO_IN), xorshift(), 4'hf);
    bus_read(reg_addr(GPIO_ADDR, GPIO_IN), rdata);
    compare_word("GPIO_IN rd_data", 32'(gpio_in), rdata);
    bus_read(reg_addr(GPIO_ADDR, GPIO_OUT), rdata);
    compare_word("GPIO_OUT rd_data", exp_out, rdata);
    compare_word("o_gpio_out", exp_out, 32'(gpio_out));
    compare_word("o_gpio_out_en", exp_en, 32'(gpio_out_en));
  endtask

  task automatic gpio_input_sync();
    logic [31:0] rdata;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #2;
      gpio_in = p_num_gpios'(xorshift());
      repeat (2) @(posedge clk);  // two sync stages
      bus_read(reg_addr(GPIO_ADDR, GPIO_IN), rdata);
      compare_word("GPIO_IN rd_data", 32'(gpio_in), rdata);
    end
  endtask

  task automatic pwm_duty();
    logic [31:0] period;
    logic [31:0] cmp_val [p_num_channels];
    int          hi_cnt [p_num_channels];
    logic [31:0] rdata;
    int          exp_hi;
    period     = 32'd9;
    cmp_val[0] = xorshift() % 32'd10;
    if (p_num_channels > 1) cmp_val[p_num_channels-1] = period + 32'd4;  // saturates
    bus_write(reg_addr(PWM0_ADDR, PWM_PERIOD), period, 4'hf);
    for (int n = 0; n < p_num_channels; n++) begin
      bus_write(reg_addr(PWM0_ADDR, int'(PWM_CMP0) + n), cmp_val[n], 4'hf);
    end
    bus_read(reg_addr(PWM0_ADDR, PWM_PERIOD), rdata);
    compare_word("PWM_PERIOD rd_data", period, rdata);
    for (int n = 0; n < p_num_channels; n++) begin
      bus_read(reg_addr(PWM0_ADDR, int'(PWM_CMP0) + n), rdata);
      compare_word($sformatf("PWM_CMP%0d rd_data", n), cmp_val[n], rdata);
      hi_cnt[n] = 0;
    end
    bus_write(reg_addr(PWM0_ADDR, PWM_CTRL), 32'h1, 4'h1);
    repeat (2) @(posedge clk);  // let the outputs settle
    for (int c = 0; c <= int'(period); c++) begin
      @(posedge clk);
      #2;
      for (int n = 0; n < p_num_channels; n++) begin
        if (pwm_out[n]) hi_cnt[n]++;
      end
    end
    for (int n = 0; n < p_num_channels; n++) begin
      exp_hi = (cmp_val[n] < period + 1) ? int'(cmp_val[n]) : int'(period + 1);
      count_check($sformatf("o_pwm_out[%0d] high cycles", n), exp_hi, hi_cnt[n]);
    end
    bus_write(reg_addr(PWM0_ADDR, PWM_CTRL), 32'h0, 4'h1);
    @(posedge clk);
    #2;
    compare_word("o_pwm_out", '0, 32'(pwm_out));
  endtask

  task automatic unmapped_access();
    logic [31:0] rdata;
    bus_write(NO_ADDR, xorshift(), 4'hf);
    bus_read(NO_ADDR, rdata);
    compare_word("unmapped rd_data", '0, rdata);
  endtask

  task automatic back_to_back();
    logic [31:0] addrs [5];
    logic [31:0] masks [5];
    logic [31:0] model [5];
    mem_req_t    seq [$];
    logic [31:0] exp_q [$];
    mem_req_t    r;
    int          idx;
    int          acks;
    int          idle;
    addrs[0] = reg_addr(GPIO_ADDR, GPIO_OUT);
    addrs[1] = reg_addr(GPIO_ADDR, GPIO_OUT_EN);
    addrs[2] = reg_addr(PWM0_ADDR, PWM_PERIOD);
    addrs[3] = reg_addr(PWM0_ADDR, PWM_CMP0);
    addrs[4] = reg_addr(PWM0_ADDR, PWM_CMP1);
    masks    = '{GPIO_MASK, GPIO_MASK, CMP_MASK, CMP_MASK, CMP_MASK};
    // full writes first so the model starts known
    for (int k = 0; k < 16; k++) begin
      idx       = (k < 5) ? k : int'(xorshift() % 32'd5);
      r         = '0;
      r.addr    = addrs[idx];
      r.wr_data = xorshift();
      r.be      = (k < 5) ? 4'hf : 4'(xorshift());
      r.wr_en   = 1'b1;
      model[idx] = apply_write((k < 5) ? '0 : model[idx], r.wr_data, r.be, masks[idx]);
      seq.push_back(r);
      exp_q.push_back('0);  // writes return zero data
    end
    for (int k = 0; k < 5; k++) begin
      r       = '0;
      r.addr  = addrs[k];
      r.rd_en = 1'b1;
      seq.push_back(r);
      exp_q.push_back(model[k]);
    end
    acks = 0;
    idle = 0;
    fork
      begin
        foreach (seq[i]) begin
          @(posedge clk);
          #2;
          req = seq[i];
        end
        @(posedge clk);
        #2;
        req = '0;
      end
      begin
        while (acks < seq.size() && idle < TIMEOUT) begin
          @(posedge clk);
          #2;
          if (rsp.ack) begin
            compare_word($sformatf("o_rsp.rd_data access %0d", acks), exp_q.pop_front(),
                         rsp.rd_data);
            acks++;
            idle = 0;
          end else begin
            idle++;
          end
        end
      end
    join
    if (acks < seq.size()) begin
      fail_cnt++;
      $display("back to back run got only %0d acks for %0d accesses", acks, seq.size());
    end
  endtask

  initial begin
    rst     = 1'b1;
    req     = '0;
    gpio_in = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_values();
    gpio_write_readback();
    gpio_input_sync();
    pwm_duty();
    unmapped_access();
    back_to_back();
    repeat (2) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #200_000;
    $display("simulation did not finish within the time limit");
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+testbench
hdl/pck_mem_bus.sv
hdl/pck_memory_map.sv
hdl/soc_bridge.sv
hdl/perif_gpio.sv
hdl/perif_pwm.sv
hdl/soc_periph.sv
testbench/tb_soc_periph.sv
